// ==== dv/tb_soc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_consts.svh"

module tb_soc_ctrl import soc_ctrl_pkg::*;;

  localparam logic [31:0] boot_addr = 32'h2000_0080;
  localparam int unsigned drain_limit = 8;

  logic         clk = 1'b0;
  logic         rst_n;
  obi_req_t     obi_req;
  obi_rsp_t     obi_rsp;
  soc_ctrl_hw_t hw;

  // Register model
  logic [31:0] m_boot_addr;
  logic [31:0] m_core_status;
  logic        m_fetch_en;
  logic        m_boot_mode;
  logic        m_sram_dly;

  // Expected responses, oldest first
  obi_r_chan_t exp_q[$];
  string       test_name;
  int unsigned seed_val;

  always #4 clk = ~clk;

  soc_ctrl_top #(
    .boot_addr_default (boot_addr)
  ) soc_ctrl_top_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .obi_req_i (obi_req),
    .obi_rsp_o (obi_rsp),
    .hw_o      (hw)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_rsp(input string what, input obi_rsp_t exp, input obi_rsp_t act);
    logic bad;
    bad = (act.gnt !== exp.gnt) || (act.rvalid !== exp.rvalid);
    // Response fields only mean something while rvalid is high
    if (exp.rvalid && act.r !== exp.r) begin
      bad = 1'b1;
    end
    if (bad) begin
      abort_run($sformatf({"** Error %s (%s): expected gnt=%b rvalid=%b rdata=%h rid=%h ",
                           "err=%b, actual gnt=%b rvalid=%b rdata=%h rid=%h err=%b"},
                          test_name, what, exp.gnt, exp.rvalid, exp.r.rdata, exp.r.rid,
                          exp.r.err, act.gnt, act.rvalid, act.r.rdata, act.r.rid,
                          act.r.err));
    end
  endtask

  task automatic check_hw(input string what, input soc_ctrl_hw_t exp, input soc_ctrl_hw_t act);
    if (act !== exp) begin
      abort_run($sformatf({"** Error %s (%s): expected fetch_en=%b sram_dly=%b, ",
                           "actual fetch_en=%b sram_dly=%b"},
                          test_name, what, exp.fetch_en, exp.sram_dly,
                          act.fetch_en, act.sram_dly));
    end
  endtask

  // Every byte enable stands for its eight data bits
  function automatic logic [31:0] be_to_mask(input logic [3:0] be);
    logic [31:0] mask;
    for (int b = 0; b < 32; b++) begin
      mask[b] = be[b / 8];
    end
    return mask;
  endfunction

  function automatic soc_ctrl_hw_t model_hw();
    soc_ctrl_hw_t h;
    h.fetch_en = m_fetch_en;
    h.sram_dly = m_sram_dly;
    return h;
  endfunction

  task automatic reset_model();
    m_boot_addr   = boot_addr;
    m_core_status = '0;
    m_fetch_en    = 1'b1;
    m_boot_mode   = 1'b0;
    m_sram_dly    = 1'b0;
  endtask

  // Applies one request to the model and gives the response it should get
  task automatic apply_to_model(input obi_a_chan_t a, output obi_r_chan_t r);
    logic [4:0]  off;
    logic [31:0] wval;
    logic        bit0;
    logic        mapped;
    off    = a.addr[4:0] & 5'h1C;
    wval   = a.wdata & be_to_mask(a.be);
    bit0   = a.wdata[0] & a.be[0];
    mapped = 1'b1;
    r      = '0;
    r.rid  = a.aid;
    if (a.we) begin
      case (off)
        `SOC_CTRL_BOOTADDR_OFFSET:   m_boot_addr = wval;
        `SOC_CTRL_FETCHEN_OFFSET:    m_fetch_en = bit0;
        `SOC_CTRL_CORESTATUS_OFFSET: m_core_status = wval;
        `SOC_CTRL_BOOTMODE_OFFSET:   m_boot_mode = bit0;
        `SOC_CTRL_SRAM_DLY_OFFSET:   m_sram_dly = bit0;
        default:                     mapped = 1'b0;
      endcase
    end else begin
      case (off)
        `SOC_CTRL_BOOTADDR_OFFSET:   r.rdata = m_boot_addr;
        `SOC_CTRL_FETCHEN_OFFSET:    r.rdata = {31'b0, m_fetch_en};
        `SOC_CTRL_CORESTATUS_OFFSET: r.rdata = m_core_status;
        `SOC_CTRL_BOOTMODE_OFFSET:   r.rdata = {31'b0, m_boot_mode};
        `SOC_CTRL_SRAM_DLY_OFFSET:   r.rdata = {31'b0, m_sram_dly};
        default: begin
          mapped  = 1'b0;
          r.rdata = `SOC_CTRL_BAD_RDATA;
        end
      endcase
    end
    r.err = ~mapped;
  endtask

  function automatic obi_req_t make_req(input logic we, input logic [31:0] addr,
                                        input logic [3:0] be, input logic [31:0] wdata);
    obi_req_t r;
    r         = '0;
    r.req     = 1'b1;
    r.a.we    = we;
    r.a.addr  = addr;
    r.a.be    = be;
    r.a.wdata = wdata;
    r.a.aid   = 4'($urandom_range(0, 15));
    return r;
  endfunction

  // Upper bits are noise when the map aliases
  function automatic logic [31:0] alias_addr(input logic [4:0] off, input logic noisy);
    logic [31:0] upper;
    upper = noisy ? $urandom : 32'h0;
    return {upper[31:5], off};
  endfunction

  // One bus cycle: check what the last cycle produced, then drive the next request
  task automatic step(input obi_req_t r);
    obi_rsp_t    exp;
    obi_r_chan_t next_r;
    @(negedge clk);
    exp     = '0;
    exp.gnt = 1'b1;
    if (exp_q.size() > 0) begin
      exp.rvalid = 1'b1;
      exp.r      = exp_q.pop_front();
    end
    check_rsp("response", exp, obi_rsp);
    check_hw("hw outputs", model_hw(), hw);
    obi_req = r;
    if (r.req) begin
      apply_to_model(r.a, next_r);
      exp_q.push_back(next_r);
    end
  endtask

  task automatic idle_cycle();
    step('0);
  endtask

  // Idles until all responses are in, then one more cycle to see rvalid drop
  task automatic drain();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == drain_limit) begin
        abort_run("Timed out waiting for outstanding responses");
      end else begin
        idle_cycle();
        waited++;
      end
    end
    idle_cycle();
  endtask

  task automatic read_reset_values();
    test_name = "reset_values";
    for (int i = 0; i < 5; i++) begin
      step(make_req(1'b0, alias_addr(5'(4 * i), 1'b0), 4'hF, '0));
    end
    drain();
  endtask

  task automatic write_masked_regs();
    logic [4:0]  off;
    logic [31:0] addr;
    test_name = "masked_writes";
    for (int reg_idx = 0; reg_idx < 5; reg_idx++) begin
      off = 5'(4 * reg_idx);
      for (int n = 0; n < 24; n++) begin
        addr = alias_addr(off, 1'b0);
        step(make_req(1'b1, addr, 4'($urandom), $urandom));
        step(make_req(1'b0, addr, 4'($urandom), $urandom));
        if ($urandom_range(0, 3) == 0) begin
          idle_cycle();
        end
      end
    end
    drain();
  endtask

  task automatic probe_unmapped();
    logic [4:0] off;
    test_name = "unmapped_and_alias";
    for (int n = 0; n < 8; n++) begin
      for (int hole = 5; hole < 8; hole++) begin
        off = 5'(4 * hole);
        step(make_req(1'b0, alias_addr(off, 1'b1), 4'($urandom), $urandom));
        step(make_req(1'b1, alias_addr(off, 1'b1), 4'($urandom), $urandom));
      end
      // Mapped registers must be untouched and reachable through any alias
      for (int i = 0; i < 5; i++) begin
        step(make_req(1'b0, alias_addr(5'(4 * i), 1'b1), 4'hF, $urandom));
      end
    end
    drain();
  endtask

  task automatic vary_request_gaps();
    int unsigned gap;
    test_name = "response_timing";
    for (int n = 0; n < 200; n++) begin
      step(make_req(1'($urandom), alias_addr(5'($urandom_range(0, 7) * 4), 1'b1),
                    4'($urandom), $urandom));
      gap = $urandom_range(0, 3);
      for (int g = 0; g < gap; g++) begin
        idle_cycle();
      end
    end
    drain();
  endtask

  task automatic stream_back_to_back();
    logic [31:0] addr;
    logic [31:0] last_addr;
    logic        follow_read;
    logic        we;
    int unsigned kind;
    test_name   = "back_to_back";
    follow_read = 1'b0;
    last_addr   = '0;
    for (int n = 0; n < 3000; n++) begin
      if (follow_read) begin
        // Read straight after a write to the same register
        step(make_req(1'b0, last_addr, 4'($urandom), $urandom));
        follow_read = 1'b0;
      end else begin
        kind = $urandom_range(0, 9);
        if (kind == 0) begin
          idle_cycle();
        end else begin
          we   = 1'($urandom);
          addr = alias_addr(5'($urandom_range(0, 7) * 4), 1'($urandom));
          addr[1:0] = 2'($urandom);
          step(make_req(we, addr, 4'($urandom), $urandom));
          if (we && kind < 5) begin
            follow_read = 1'b1;
            last_addr   = addr;
          end
        end
      end
    end
    drain();
  endtask

  initial begin
    seed_val  = $urandom(32'h5541_e12f);
    test_name = "reset";
    rst_n     = 1'b0;
    obi_req   = '0;
    reset_model();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    read_reset_values();
    write_masked_regs();
    probe_unmapped();
    vary_request_gaps();
    stream_back_to_back();

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_consts.svh"

module soc_ctrl_decode import soc_ctrl_pkg::*; (
  input  obi_req_t         obi_req_i,
  output soc_ctrl_access_t access_o
);

  // Word-aligned offset within the register window
  logic [`SOC_CTRL_INT_ADDR_W-1:0] offset;
  logic [`SOC_CTRL_DATA_W-1:0]     be_mask;
  logic                            unmapped;
  reg_sel_e                        sel;

  // Upper address bits are dropped, so the map repeats
  assign offset = {obi_req_i.a.addr[`SOC_CTRL_INT_ADDR_W-1:2], 2'b00};

  // One byte enable covers eight data bits
  for (genvar i = 0; i < `SOC_CTRL_DATA_W/8; i++) begin : gen_be_mask
    assign be_mask[8*i +: 8] = {8{obi_req_i.a.be[i]}};
  end

  always_comb begin
    case (offset)
      `SOC_CTRL_BOOTADDR_OFFSET:   sel = REG_BOOTADDR;
      `SOC_CTRL_FETCHEN_OFFSET:    sel = REG_FETCHEN;
      `SOC_CTRL_CORESTATUS_OFFSET: sel = REG_CORESTATUS;
      `SOC_CTRL_BOOTMODE_OFFSET:   sel = REG_BOOTMODE;
      `SOC_CTRL_SRAM_DLY_OFFSET:   sel = REG_SRAM_DLY;
      default:                     sel = REG_NONE;
    endcase
  end

  // Registers are packed from zero up, anything above the last one is a hole
  assign unmapped = (offset > `SOC_CTRL_SRAM_DLY_OFFSET);

  always_comb begin
    access_o         = '0;
    access_o.valid   = obi_req_i.req;
    access_o.we      = obi_req_i.a.we;
    access_o.sel     = sel;
    access_o.wdata   = obi_req_i.a.wdata;
    access_o.be_mask = be_mask;
    access_o.aid     = obi_req_i.a.aid;
    access_o.err     = obi_req_i.req & unmapped;
  end

  // Range check and select decode must agree on every request
  always_comb begin
    if (access_o.valid) begin
      assert final (access_o.err == (access_o.sel == REG_NONE))
        else $error("decode: err and sel disagree at offset %h", offset);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl_pkg.sv ====
`default_nettype none

`include "soc_ctrl_consts.svh"

package soc_ctrl_pkg;

  // OBI request channel
  typedef struct packed {
    logic [`SOC_CTRL_ADDR_W-1:0]   addr;
    logic                          we;
    logic [`SOC_CTRL_DATA_W/8-1:0] be;
    logic [`SOC_CTRL_DATA_W-1:0]   wdata;
    logic [`SOC_CTRL_ID_W-1:0]     aid;
  } obi_a_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  // OBI response channel
  typedef struct packed {
    logic [`SOC_CTRL_DATA_W-1:0] rdata;
    logic [`SOC_CTRL_ID_W-1:0]   rid;
    logic                        err;
  } obi_r_chan_t;

  // No rready, so the response is never held off
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

  typedef enum logic [2:0] {
    REG_BOOTADDR,
    REG_FETCHEN,
    REG_CORESTATUS,
    REG_BOOTMODE,
    REG_SRAM_DLY,
    REG_NONE
  } reg_sel_e;

  // One request after address and byte-enable decode
  typedef struct packed {
    logic                        valid;
    logic                        we;
    reg_sel_e                    sel;
    logic [`SOC_CTRL_DATA_W-1:0] wdata;
    logic [`SOC_CTRL_DATA_W-1:0] be_mask;
    logic [`SOC_CTRL_ID_W-1:0]   aid;
    logic                        err;
  } soc_ctrl_access_t;

  // Outputs to the core and SRAM
  typedef struct packed {
    logic fetch_en;
    logic sram_dly;
  } soc_ctrl_hw_t;

endpackage

`default_nettype wire

// ==== hdl/soc_ctrl_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_consts.svh"

module soc_ctrl_regfile import soc_ctrl_pkg::*; #(
  parameter logic [`SOC_CTRL_DATA_W-1:0] boot_addr_default = `SOC_CTRL_BOOT_ADDR_DEFAULT
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  soc_ctrl_access_t            access_i,
  output logic [`SOC_CTRL_DATA_W-1:0] rdata_o,
  output soc_ctrl_hw_t                hw_o
);

  localparam int unsigned DataW = `SOC_CTRL_DATA_W;

  // Register state
  logic [DataW-1:0] boot_addr_q;
  logic [DataW-1:0] core_status_q;
  logic             fetch_en_q;
  logic             boot_mode_q;
  logic             sram_dly_q;

  logic [DataW-1:0] wdata_masked;
  logic             wr_en;
  logic             rd_en;

  // Disabled lanes are written as zero, not kept
  assign wdata_masked = access_i.wdata & access_i.be_mask;

  assign wr_en = access_i.valid & access_i.we;
  assign rd_en = access_i.valid & ~access_i.we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q   <= boot_addr_default;
      core_status_q <= '0;
      fetch_en_q    <= 1'b1;
      boot_mode_q   <= 1'b0;
      sram_dly_q    <= 1'b0;
    end else if (wr_en) begin
      case (access_i.sel)
        REG_BOOTADDR:   boot_addr_q   <= wdata_masked;
        REG_CORESTATUS: core_status_q <= wdata_masked;
        // Single-bit registers see only lane 0
        REG_FETCHEN:    fetch_en_q    <= wdata_masked[0];
        REG_BOOTMODE:   boot_mode_q   <= wdata_masked[0];
        REG_SRAM_DLY:   sram_dly_q    <= wdata_masked[0];
        default: begin
        end
      endcase
    end
  end

  // Read mux works on current state, so a read sees all earlier writes
  always_comb begin
    rdata_o = '0;
    if (rd_en) begin
      case (access_i.sel)
        REG_BOOTADDR:   rdata_o = boot_addr_q;
        REG_FETCHEN:    rdata_o = {{(DataW-1){1'b0}}, fetch_en_q};
        REG_CORESTATUS: rdata_o = core_status_q;
        REG_BOOTMODE:   rdata_o = {{(DataW-1){1'b0}}, boot_mode_q};
        REG_SRAM_DLY:   rdata_o = {{(DataW-1){1'b0}}, sram_dly_q};
        default:        rdata_o = `SOC_CTRL_BAD_RDATA;
      endcase
    end
  end

  // To hardware
  assign hw_o.fetch_en = fetch_en_q;
  assign hw_o.sram_dly = sram_dly_q;

  // Control bits must stay known for the core and SRAM
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({fetch_en_q, boot_mode_q, sram_dly_q}))
    else $error("regfile: single-bit register holds X");

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl_resp.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_consts.svh"

module soc_ctrl_resp import soc_ctrl_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  soc_ctrl_access_t            access_i,
  input  logic [`SOC_CTRL_DATA_W-1:0] rdata_i,
  output obi_rsp_t                    obi_rsp_o
);

  logic        rvalid_q;
  obi_r_chan_t r_q;

  // Response for the request seen one cycle back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      r_q      <= '0;
    end else begin
      rvalid_q  <= access_i.valid;
      r_q.rdata <= rdata_i;
      r_q.rid   <= access_i.aid;
      r_q.err   <= access_i.err;
    end
  end

  // Never stalls, so grant stays high
  always_comb begin
    obi_rsp_o        = '0;
    obi_rsp_o.gnt    = 1'b1;
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.r      = r_q;
  end

  // Each response belongs to a request one cycle earlier
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    obi_rsp_o.rvalid |-> $past(access_i.valid))
    else $error("resp: rvalid without a request in the previous cycle");

endmodule

`default_nettype wire

// ==== hdl/soc_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_ctrl_consts.svh"

module soc_ctrl_top import soc_ctrl_pkg::*; #(
  parameter logic [`SOC_CTRL_DATA_W-1:0] boot_addr_default = `SOC_CTRL_BOOT_ADDR_DEFAULT
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  obi_req_t     obi_req_i,
  output obi_rsp_t     obi_rsp_o,
  output soc_ctrl_hw_t hw_o
);

  soc_ctrl_access_t            access;
  logic [`SOC_CTRL_DATA_W-1:0] rdata;

  // Request decode, combinational
  soc_ctrl_decode soc_ctrl_decode_i (
    .obi_req_i (obi_req_i),
    .access_o  (access)
  );

  soc_ctrl_regfile #(
    .boot_addr_default (boot_addr_default)
  ) soc_ctrl_regfile_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .access_i (access),
    .rdata_o  (rdata),
    .hw_o     (hw_o)
  );

  // One cycle of response latency
  soc_ctrl_resp soc_ctrl_resp_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .access_i  (access),
    .rdata_i   (rdata),
    .obi_rsp_o (obi_rsp_o)
  );

endmodule

`default_nettype wire

// ==== include/soc_ctrl_consts.svh ====
`ifndef SOC_CTRL_CONSTS_SVH
`define SOC_CTRL_CONSTS_SVH

// OBI bus widths
`define SOC_CTRL_ADDR_W 32
`define SOC_CTRL_DATA_W 32
`define SOC_CTRL_ID_W   4

// Address bits that select a register, the rest alias
`define SOC_CTRL_INT_ADDR_W 5

// Register offsets within the window
`define SOC_CTRL_BOOTADDR_OFFSET   5'h00
`define SOC_CTRL_FETCHEN_OFFSET    5'h04
`define SOC_CTRL_CORESTATUS_OFFSET 5'h08
`define SOC_CTRL_BOOTMODE_OFFSET   5'h0C
`define SOC_CTRL_SRAM_DLY_OFFSET   5'h10

// Read data for a hole in the map
`define SOC_CTRL_BAD_RDATA 32'hBADCAB1E

// Boot address after reset
`define SOC_CTRL_BOOT_ADDR_DEFAULT 32'h1C00_0000

`endif

// ==== tb.f ====
+incdir+include
hdl/soc_ctrl_pkg.sv
hdl/soc_ctrl_decode.sv
hdl/soc_ctrl_regfile.sv
hdl/soc_ctrl_resp.sv
hdl/soc_ctrl_top.sv
dv/tb_soc_ctrl.sv
